// ==== hdl/db_config.svh ====
`ifndef DB_CONFIG_SVH
`define DB_CONFIG_SVH

// pixel and bank geometry
`define DB_PIXEL_WIDTH 8
`define DB_RAM_DEPTH   208   // words per bank
`define DB_ADDR_W      8

// axi4-lite bus
`define DB_AXI_AW 8
`define DB_AXI_DW 32

// register map, byte offsets
`define DB_REG_WDATA0 8'h00  // wdata0..3 at 0x00-0x0c
`define DB_REG_CTRL   8'h10
`define DB_REG_PAD    8'h14
`define DB_REG_RADDR  8'h18
`define DB_REG_STATUS 8'h1C
`define DB_REG_RDATA0 8'h20  // rdata0..7 at 0x20-0x3c

`endif

// ==== hdl/db_pkg.sv ====
package db_pkg;

  // write select, bit 1 picks chroma
  typedef enum logic [1:0] {
    LUMA_A   = 2'd0,  // blk_x[0] picks the half
    LUMA_B   = 2'd1,
    CHROMA_U = 2'd2,  // upper half of a chroma word
    CHROMA_V = 2'd3   // lower half
  } plane_e;

  typedef enum logic {
    HOST = 1'b0,
    PAD  = 1'b1
  } wr_id_e;

  typedef enum logic [1:0] {
    PAD_IDLE,
    PAD_LUMA,
    PAD_CHROMA_U,
    PAD_CHROMA_V
  } pad_state_e;

  typedef enum logic [1:0] {
    AX_IDLE,
    AX_WAIT_GNT,  // block write queued at the arbiter
    AX_RD_WAIT,
    AX_RESP
  } axil_state_e;

endpackage

// ==== hdl/db_wr_if.sv ====
`include "db_config.svh"

interface db_wr_if
  import db_pkg::*;
();

  logic                           req;
  plane_e                         plane;
  logic [3:0]                     blk_x;  // 4x4 column
  logic [4:0]                     blk_y;  // 4x4 row
  logic [`DB_PIXEL_WIDTH*16-1:0]  wdata;  // row 0 pixel 0 in the msbs
  logic                           gnt;

  modport requester (
    output req, plane, blk_x, blk_y, wdata,
    input  gnt
  );

  modport arbiter (
    input  req, plane, blk_x, blk_y, wdata,
    output gnt
  );

endinterface

// ==== hdl/buf_ram_2p.sv ====
`include "db_config.svh"

module buf_ram_2p (
  input  logic                          clk,
  input  logic [1:0]                    a_we_i,    // [1] upper half, [0] lower half
  input  logic [`DB_ADDR_W-1:0]         a_addr_i,
  input  logic [`DB_PIXEL_WIDTH*8-1:0]  a_data_i,
  input  logic                          b_re_i,
  input  logic [`DB_ADDR_W-1:0]         b_addr_i,
  output logic [`DB_PIXEL_WIDTH*8-1:0]  b_data_o
);

  localparam int HW = `DB_PIXEL_WIDTH*4;  // one 4-pixel row

  logic [`DB_PIXEL_WIDTH*8-1:0] mem [`DB_RAM_DEPTH];

  always_ff @(posedge clk) begin
    if (a_we_i[1])
      mem[a_addr_i][2*HW-1:HW] <= a_data_i[2*HW-1:HW];
    if (a_we_i[0])
      mem[a_addr_i][HW-1:0] <= a_data_i[HW-1:0];
  end

  always_ff @(posedge clk) begin
    if (b_re_i)
      b_data_o <= mem[b_addr_i];  // holds between reads
  end

  a_waddr_range: assert property (@(posedge clk) (|a_we_i) |-> (a_addr_i < `DB_RAM_DEPTH));

endmodule

// ==== hdl/db_bank_mem.sv ====
`include "db_config.svh"

module db_bank_mem
  import db_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           wen_i,
  input  plane_e                         wsel_i,
  input  logic [3:0]                     w4x4_x_i,
  input  logic [4:0]                     w4x4_y_i,
  input  logic [`DB_PIXEL_WIDTH*16-1:0]  wdata_i,
  input  logic                           ren_i,
  input  logic [`DB_ADDR_W-1:0]          raddr_i,
  output logic [`DB_PIXEL_WIDTH*32-1:0]  rdata_o
);

  localparam int RW = `DB_PIXEL_WIDTH*4;  // one block row
  localparam int WW = `DB_PIXEL_WIDTH*8;  // bank word

  // row offset of a column group across the four banks
  function automatic logic [1:0] rot_shift(input logic [1:0] grp);
    case (grp)
      2'd0:    return 2'd0;
      2'd1:    return 2'd2;
      2'd2:    return 2'd3;
      default: return 2'd1;
    endcase
  endfunction

  logic          is_chroma;
  logic          is_top;
  logic [1:0]    grp;
  logic [1:0]    shift;
  logic [1:0]    we_half;
  logic [5:0]    waddr_h;
  logic [1:0]    raddr_r;
  logic [WW-1:0] bank_rdata [4];

  assign is_chroma = wsel_i[1];
  assign is_top    = is_chroma ? w4x4_y_i[3] : w4x4_y_i[4];  // neighbour line above
  assign grp       = is_chroma ? w4x4_x_i[1:0] : w4x4_x_i[2:1];
  assign shift     = rot_shift(grp);

  // luma halves by column parity, chroma halves by plane
  always_comb begin
    if (!wen_i)
      we_half = 2'b00;
    else if (is_chroma)
      we_half = {~wsel_i[0], wsel_i[0]};
    else
      we_half = {~w4x4_x_i[0], w4x4_x_i[0]};
  end

  // cur luma 0-127, cur chroma 128-191, top luma 192-199, top chroma 200-207
  always_comb begin
    case ({is_top, is_chroma})
      2'b00:   waddr_h = {1'b0, w4x4_y_i[3], w4x4_x_i[3], w4x4_y_i[2:0]};
      2'b01:   waddr_h = {2'b10, w4x4_y_i[2:0], w4x4_x_i[2]};
      2'b10:   waddr_h = {5'b11000, w4x4_x_i[3]};
      default: waddr_h = {5'b11001, w4x4_x_i[2]};
    endcase
  end

  for (genvar k = 0; k < 4; k++) begin : g_bank
    logic [1:0]    row;
    logic [RW-1:0] row_data;

    assign row      = 2'(k) + shift;  // block row that lands in bank k
    assign row_data = wdata_i[(3 - int'(row))*RW +: RW];

    buf_ram_2p u_ram (
      .clk      (clk),
      .a_we_i   (we_half),
      .a_addr_i ({waddr_h, row}),
      .a_data_i ({row_data, row_data}),
      .b_re_i   (ren_i),
      .b_addr_i (raddr_i),
      .b_data_o (bank_rdata[k])
    );
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      raddr_r <= 2'd0;
    else if (ren_i)
      raddr_r <= raddr_i[1:0];  // follows the ram output
  end

  // group g of the requested row sits in bank (row - shift(g))
  always_comb begin
    for (int g = 0; g < 4; g++)
      rdata_o[(3-g)*WW +: WW] = bank_rdata[2'(raddr_r - rot_shift(2'(g)))];
  end

  // chroma rows stop at 8 plus the top line
  a_chroma_y: assert property (@(posedge clk) disable iff (!rst_n)
    (wen_i && wsel_i[1]) |-> !w4x4_y_i[4]);

endmodule

// ==== hdl/db_wr_arb.sv ====
`include "db_config.svh"

module db_wr_arb
  import db_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  db_wr_if.arbiter                       host,
  db_wr_if.arbiter                       pad,
  output logic                           wen_o,
  output plane_e                         wsel_o,
  output logic [3:0]                     w4x4_x_o,
  output logic [4:0]                     w4x4_y_o,
  output logic [`DB_PIXEL_WIDTH*16-1:0]  wdata_o
);

  wr_id_e last_id;

  assign host.gnt = host.req;  // host always wins
  assign pad.gnt  = pad.req & ~host.req;
  assign wen_o    = host.req | pad.req;

  always_comb begin
    if (host.req) begin
      wsel_o   = host.plane;
      w4x4_x_o = host.blk_x;
      w4x4_y_o = host.blk_y;
      wdata_o  = host.wdata;
    end else begin
      wsel_o   = pad.plane;
      w4x4_x_o = pad.blk_x;
      w4x4_y_o = pad.blk_y;
      wdata_o  = pad.wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      last_id <= HOST;
    else if (wen_o)
      last_id <= host.req ? HOST : PAD;
  end

  a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n) !(host.gnt && pad.gnt));

  // a stalled pad write lost to the host and keeps its block
  a_pad_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (pad.req && !pad.gnt) |=> (last_id == HOST) && pad.req &&
                              $stable(pad.blk_x) && $stable(pad.blk_y));

endmodule

// ==== hdl/db_pad_fill.sv ====
`include "db_config.svh"

module db_pad_fill
  import db_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        start_i,
  input  logic [`DB_PIXEL_WIDTH-1:0]  pad_value_i,
  output logic                        busy_o,
  db_wr_if.requester                  wr
);

  pad_state_e                  state;
  logic [3:0]                  blk_cnt;
  logic [`DB_PIXEL_WIDTH-1:0]  pad_r;
  logic                        last_blk;

  // 16 luma columns, 8 per chroma plane
  assign last_blk = (state == PAD_LUMA) ? (blk_cnt == 4'd15) : (blk_cnt == 4'd7);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= PAD_IDLE;
      blk_cnt <= 4'd0;
    end else if (state == PAD_IDLE) begin
      if (start_i)
        state <= PAD_LUMA;
    end else if (wr.gnt) begin
      blk_cnt <= last_blk ? 4'd0 : blk_cnt + 4'd1;
      if (last_blk) begin
        case (state)
          PAD_LUMA:     state <= PAD_CHROMA_U;
          PAD_CHROMA_U: state <= PAD_CHROMA_V;
          default:      state <= PAD_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == PAD_IDLE && start_i)
      pad_r <= pad_value_i;  // fixed for the whole fill
  end

  assign busy_o   = (state != PAD_IDLE);
  assign wr.req   = busy_o;
  assign wr.blk_x = (state == PAD_LUMA) ? blk_cnt : {1'b0, blk_cnt[2:0]};
  assign wr.blk_y = (state == PAD_LUMA) ? 5'd16 : 5'd8;  // top neighbour row
  assign wr.wdata = {16{pad_r}};

  always_comb begin
    case (state)
      PAD_CHROMA_U: wr.plane = CHROMA_U;
      PAD_CHROMA_V: wr.plane = CHROMA_V;
      default:      wr.plane = blk_cnt[0] ? LUMA_B : LUMA_A;
    endcase
  end

endmodule

// ==== hdl/db_axil_regs.sv ====
`include "db_config.svh"

module db_axil_regs
  import db_pkg::*;
(
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic [`DB_AXI_AW-1:0]          s_awaddr_i,
  input  logic                           s_awvalid_i,
  output logic                           s_awready_o,
  input  logic [`DB_AXI_DW-1:0]          s_wdata_i,
  input  logic                           s_wvalid_i,
  output logic                           s_wready_o,
  output logic                           s_bvalid_o,
  input  logic                           s_bready_i,
  input  logic [`DB_AXI_AW-1:0]          s_araddr_i,
  input  logic                           s_arvalid_i,
  output logic                           s_arready_o,
  output logic [`DB_AXI_DW-1:0]          s_rdata_o,
  output logic                           s_rvalid_o,
  input  logic                           s_rready_i,
  db_wr_if.requester                     wr,
  output logic                           pad_start_o,
  output logic [`DB_PIXEL_WIDTH-1:0]     pad_value_o,
  input  logic                           pad_busy_i,
  output logic                           ren_o,
  output logic [`DB_ADDR_W-1:0]          raddr_o,
  input  logic [`DB_PIXEL_WIDTH*32-1:0]  rdata_i
);

  localparam int                  DW         = `DB_AXI_DW;
  localparam logic [`DB_AXI_AW-1:0] WDATA_BASE = `DB_REG_WDATA0;
  localparam logic [`DB_AXI_AW-1:0] RDATA_BASE = `DB_REG_RDATA0;

  axil_state_e                    state;
  logic                           idle_free;
  logic                           wr_acc;
  logic                           rd_acc;
  logic [DW-1:0]                  wdata_r [4];
  logic [`DB_PIXEL_WIDTH*32-1:0]  rdata_r;
  logic [DW-1:0]                  rd_word;

  assign idle_free = (state == AX_IDLE) && !s_awready_o && !s_arready_o;
  assign wr_acc    = s_awready_o && s_awvalid_i && s_wvalid_i;
  assign rd_acc    = s_arready_o && s_arvalid_i;
  assign wr.wdata  = {wdata_r[0], wdata_r[1], wdata_r[2], wdata_r[3]};

  // one-cycle ready pulses, writes first
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s_awready_o <= 1'b0;
      s_wready_o  <= 1'b0;
      s_arready_o <= 1'b0;
    end else begin
      s_awready_o <= idle_free && s_awvalid_i && s_wvalid_i;
      s_wready_o  <= idle_free && s_awvalid_i && s_wvalid_i;
      s_arready_o <= idle_free && s_arvalid_i && !(s_awvalid_i && s_wvalid_i);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= AX_IDLE;
      s_bvalid_o  <= 1'b0;
      s_rvalid_o  <= 1'b0;
      pad_start_o <= 1'b0;
      pad_value_o <= '0;
      ren_o       <= 1'b0;
      raddr_o     <= '0;
      wr.req      <= 1'b0;
      wr.plane    <= LUMA_A;
      wr.blk_x    <= '0;
      wr.blk_y    <= '0;
    end else begin
      pad_start_o <= 1'b0;
      case (state)
        AX_IDLE: begin
          if (wr_acc) begin
            case (s_awaddr_i)
              `DB_REG_CTRL: begin
                wr.plane <= plane_e'(s_wdata_i[1:0]);
                wr.blk_x <= s_wdata_i[6:3];
                wr.blk_y <= s_wdata_i[12:8];
                wr.req   <= 1'b1;
                state    <= AX_WAIT_GNT;
              end
              `DB_REG_RADDR: begin
                raddr_o <= s_wdata_i[`DB_ADDR_W-1:0];
                ren_o   <= 1'b1;
                state   <= AX_RD_WAIT;
              end
              default: begin  // data regs, pad or unmapped
                if (s_awaddr_i == `DB_REG_PAD) begin
                  pad_value_o <= s_wdata_i[`DB_PIXEL_WIDTH-1:0];
                  pad_start_o <= 1'b1;
                end
                s_bvalid_o <= 1'b1;
                state      <= AX_RESP;
              end
            endcase
          end else if (rd_acc) begin
            s_rvalid_o <= 1'b1;
            state      <= AX_RESP;
          end
        end
        AX_WAIT_GNT: begin
          if (wr.gnt) begin
            wr.req     <= 1'b0;
            s_bvalid_o <= 1'b1;
            state      <= AX_RESP;
          end
        end
        AX_RD_WAIT: begin
          if (ren_o) begin
            ren_o <= 1'b0;
          end else begin
            s_bvalid_o <= 1'b1;  // rdata captured this cycle
            state      <= AX_RESP;
          end
        end
        default: begin
          if (s_bvalid_o && s_bready_i) begin
            s_bvalid_o <= 1'b0;
            state      <= AX_IDLE;
          end
          if (s_rvalid_o && s_rready_i) begin
            s_rvalid_o <= 1'b0;
            state      <= AX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_acc && s_awaddr_i[7:4] == WDATA_BASE[7:4])
      wdata_r[s_awaddr_i[3:2]] <= s_wdata_i;
    if (state == AX_RD_WAIT && !ren_o)
      rdata_r <= rdata_i;
    if (rd_acc)
      s_rdata_o <= rd_word;
  end

  always_comb begin
    rd_word = '0;  // unmapped
    if (s_araddr_i[7:4] == WDATA_BASE[7:4]) begin
      rd_word = wdata_r[s_araddr_i[3:2]];
    end else if (s_araddr_i[7:5] == RDATA_BASE[7:5]) begin
      rd_word = rdata_r[(7 - s_araddr_i[4:2])*DW +: DW];  // rdata0 holds pixels 0-3
    end else begin
      case (s_araddr_i)
        `DB_REG_CTRL:   rd_word = DW'({wr.blk_y, 1'b0, wr.blk_x, 1'b0, wr.plane});
        `DB_REG_PAD:    rd_word = DW'(pad_value_o);
        `DB_REG_RADDR:  rd_word = DW'(raddr_o);
        `DB_REG_STATUS: rd_word = DW'(pad_busy_i);
        default:        rd_word = '0;
      endcase
    end
  end

endmodule

// ==== hdl/db_buf_top.sv ====
`include "db_config.svh"

module db_buf_top
  import db_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`DB_AXI_AW-1:0]  s_awaddr_i,
  input  logic                   s_awvalid_i,
  output logic                   s_awready_o,
  input  logic [`DB_AXI_DW-1:0]  s_wdata_i,
  input  logic                   s_wvalid_i,
  output logic                   s_wready_o,
  output logic                   s_bvalid_o,
  input  logic                   s_bready_i,
  input  logic [`DB_AXI_AW-1:0]  s_araddr_i,
  input  logic                   s_arvalid_i,
  output logic                   s_arready_o,
  output logic [`DB_AXI_DW-1:0]  s_rdata_o,
  output logic                   s_rvalid_o,
  input  logic                   s_rready_i
);

  db_wr_if u_host_if ();
  db_wr_if u_pad_if ();

  logic                           pad_start;
  logic [`DB_PIXEL_WIDTH-1:0]     pad_value;
  logic                           pad_busy;
  logic                           ren;
  logic [`DB_ADDR_W-1:0]          raddr;
  logic [`DB_PIXEL_WIDTH*32-1:0]  rdata;
  logic                           wen;
  plane_e                         wsel;
  logic [3:0]                     w4x4_x;
  logic [4:0]                     w4x4_y;
  logic [`DB_PIXEL_WIDTH*16-1:0]  wdata;

  db_axil_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .wr          (u_host_if.requester),
    .pad_start_o (pad_start),
    .pad_value_o (pad_value),
    .pad_busy_i  (pad_busy),
    .ren_o       (ren),
    .raddr_o     (raddr),
    .rdata_i     (rdata)
  );

  db_pad_fill u_pad (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (pad_start),
    .pad_value_i (pad_value),
    .busy_o      (pad_busy),
    .wr          (u_pad_if.requester)
  );

  db_wr_arb u_arb (
    .clk      (clk),
    .rst_n    (rst_n),
    .host     (u_host_if.arbiter),
    .pad      (u_pad_if.arbiter),
    .wen_o    (wen),
    .wsel_o   (wsel),
    .w4x4_x_o (w4x4_x),
    .w4x4_y_o (w4x4_y),
    .wdata_o  (wdata)
  );

  db_bank_mem u_mem (
    .clk      (clk),
    .rst_n    (rst_n),
    .wen_i    (wen),
    .wsel_i   (wsel),
    .w4x4_x_i (w4x4_x),
    .w4x4_y_i (w4x4_y),
    .wdata_i  (wdata),
    .ren_i    (ren),
    .raddr_i  (raddr),
    .rdata_o  (rdata)
  );

endmodule

// ==== test/tb_db_buf.sv ====
`include "db_config.svh"

module tb_db_buf;

  localparam string STIM_FILE = "test/db_stimulus.txt";

  logic                   clk;
  logic                   rst_n;
  logic [`DB_AXI_AW-1:0]  s_awaddr;
  logic                   s_awvalid;
  logic                   s_awready;
  logic [`DB_AXI_DW-1:0]  s_wdata;
  logic                   s_wvalid;
  logic                   s_wready;
  logic                   s_bvalid;
  logic                   s_bready;
  logic [`DB_AXI_AW-1:0]  s_araddr;
  logic                   s_arvalid;
  logic                   s_arready;
  logic [`DB_AXI_DW-1:0]  s_rdata;
  logic                   s_rvalid;
  logic                   s_rready;

  // parsed commands, one entry per stimulus line
  byte                    q_cmd [$];
  logic [`DB_AXI_AW-1:0]  q_addr [$];
  logic [`DB_AXI_DW-1:0]  q_val [$];

  int cycle_cnt   = 0;
  int cycle_limit = 0;  // set once the file is loaded
  int checks_done = 0;

  db_buf_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_awaddr_i  (s_awaddr),
    .s_awvalid_i (s_awvalid),
    .s_awready_o (s_awready),
    .s_wdata_i   (s_wdata),
    .s_wvalid_i  (s_wvalid),
    .s_wready_o  (s_wready),
    .s_bvalid_o  (s_bvalid),
    .s_bready_i  (s_bready),
    .s_araddr_i  (s_araddr),
    .s_arvalid_i (s_arvalid),
    .s_arready_o (s_arready),
    .s_rdata_o   (s_rdata),
    .s_rvalid_o  (s_rvalid),
    .s_rready_i  (s_rready)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
      fail_run();
    end
  end

  task automatic fail_run();
    $display("Something failed");
    $fatal(1, "run stopped at the first error");
  endtask

  function automatic string reg_name(input logic [`DB_AXI_AW-1:0] addr);
    string name;
    case (addr)
      `DB_REG_CTRL:   name = "CTRL";
      `DB_REG_PAD:    name = "PAD";
      `DB_REG_RADDR:  name = "RADDR";
      `DB_REG_STATUS: name = "STATUS";
      default: begin
        if (addr < `DB_REG_CTRL)
          name = $sformatf("WDATA%0d", addr[3:2]);
        else if (addr >= `DB_REG_RDATA0 && addr < 8'h40)
          name = $sformatf("RDATA%0d", addr[4:2]);
        else
          name = $sformatf("unmapped_%02h", addr);
      end
    endcase
    return name;
  endfunction

  task automatic check_word(input string name, input logic [`DB_AXI_DW-1:0] got,
                            input logic [`DB_AXI_DW-1:0] exp);
    checks_done++;
    if (got !== exp) begin
      $display("ERR t=%0t %s got %08h expected %08h", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic expect_flag(input string name, input logic got, input logic exp);
    checks_done++;
    if (got !== exp) begin
      $display("ERR t=%0t %s got %0b expected %0b", $time, name, got, exp);
      fail_run();
    end
  endtask

  // valids raised here, dropped the cycle after the ready pulse
  task automatic write_reg(input logic [`DB_AXI_AW-1:0] addr,
                           input logic [`DB_AXI_DW-1:0] data);
    s_awaddr  = addr;
    s_wdata   = data;
    s_awvalid = 1'b1;
    s_wvalid  = 1'b1;
    @(posedge clk);
    #1;
    while (!s_awready) begin
      @(posedge clk);
      #1;
    end
    expect_flag("s_wready", s_wready, 1'b1);  // raised with awready
    @(posedge clk);
    #1;
    s_awvalid = 1'b0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b1;
    while (!s_bvalid) begin  // ctrl and raddr writes take longer
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    s_bready = 1'b0;
  endtask

  task automatic read_reg(input logic [`DB_AXI_AW-1:0] addr,
                          output logic [`DB_AXI_DW-1:0] data);
    s_araddr  = addr;
    s_arvalid = 1'b1;
    @(posedge clk);
    #1;
    while (!s_arready) begin
      @(posedge clk);
      #1;
    end
    @(posedge clk);
    #1;
    s_arvalid = 1'b0;
    while (!s_rvalid) begin
      @(posedge clk);
      #1;
    end
    data     = s_rdata;
    s_rready = 1'b1;
    @(posedge clk);
    #1;
    s_rready = 1'b0;
  endtask

  task automatic wait_pad_idle();
    logic [`DB_AXI_DW-1:0] status;
    status = '1;
    while (status != '0)
      read_reg(`DB_REG_STATUS, status);
  endtask

  task automatic load_stimulus();
    int                     fd;
    int                     n;
    logic [63:0]            tok;
    logic [8*256-1:0]       rest;
    logic [`DB_AXI_AW-1:0]  addr;
    logic [`DB_AXI_DW-1:0]  val;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", STIM_FILE);
      fail_run();
    end
    while (!$feof(fd)) begin
      tok = '0;
      n = $fscanf(fd, "%s", tok);
      if (n != 1)
        break;
      if (tok == "#") begin
        n = $fgets(rest, fd);  // rest of a comment line
      end else if (tok == "P") begin
        q_cmd.push_back("P");
        q_addr.push_back(8'h00);
        q_val.push_back(32'h0);
      end else if (tok == "W" || tok == "R") begin
        n = $fscanf(fd, "%h %h", addr, val);
        if (n != 2) begin
          $display("stimulus command %s is missing its address or value", tok);
          fail_run();
        end
        q_cmd.push_back(tok[7:0]);
        q_addr.push_back(addr);
        q_val.push_back(val);
      end else begin
        $display("unknown command %s in the stimulus file", tok);
        fail_run();
      end
    end
    $fclose(fd);
  endtask

  initial begin
    logic [`DB_AXI_DW-1:0] got;
    clk       = 1'b0;
    rst_n     = 1'b0;
    s_awaddr  = '0;
    s_awvalid = 1'b0;
    s_wdata   = '0;
    s_wvalid  = 1'b0;
    s_bready  = 1'b0;
    s_araddr  = '0;
    s_arvalid = 1'b0;
    s_rready  = 1'b0;
    load_stimulus();
    cycle_limit = 40 * q_cmd.size() + 200;  // budget per command plus reset margin
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < q_cmd.size(); i++) begin
      case (q_cmd[i])
        "W": write_reg(q_addr[i], q_val[i]);
        "R": begin
          read_reg(q_addr[i], got);
          check_word(reg_name(q_addr[i]), got, q_val[i]);
        end
        default: wait_pad_idle();
      endcase
    end
    if (checks_done == 0) begin
      $display("the stimulus file held no read checks");
      fail_run();
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// ==== flist.f ====
+incdir+hdl
hdl/db_pkg.sv
hdl/db_wr_if.sv
hdl/buf_ram_2p.sv
hdl/db_bank_mem.sv
hdl/db_wr_arb.sv
hdl/db_pad_fill.sv
hdl/db_axil_regs.sv
hdl/db_buf_top.sv
test/tb_db_buf.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert -j 0 --top-module tb_db_buf -f flist.f -o tb_db_buf
	./obj_dir/tb_db_buf

clean:
	rm -rf obj_dir

.PHONY: sim clean

// ==== test/db_stimulus.txt ====
# columns: command, byte address (hex), write data or expected read data (hex)
# W writes a register, R reads and compares, P polls STATUS until the pad fill is idle
# luma block x=0 y=0, rows 0-3 come back at raddr 0-3
W 00 00010203
W 04 10111213
W 08 20212223
W 0C 30313233
W 10 00000000
W 18 00
R 20 00010203
W 18 01
R 20 10111213
W 18 02
R 20 20212223
W 18 03
R 20 30313233
# luma blocks x=3, 4 and 7 with a new row 0, rows 1-3 keep the data above
W 00 3A3B3C3D
W 10 00000018
W 00 4A4B4C4D
W 10 00000020
W 00 7A7B7C7D
W 10 00000039
W 18 00
R 20 00010203
R 2C 3A3B3C3D
R 30 4A4B4C4D
R 3C 7A7B7C7D
W 18 03
R 2C 30313233
R 3C 30313233
# U and V blocks at x=1 share the chroma word at 0x80
W 00 C0C1C2C3
W 10 0000000A
W 00 D0D1D2D3
W 10 0000000B
W 18 80
R 28 C0C1C2C3
R 2C D0D1D2D3
# pad fill with 0x5A, host block x=8 y=1 written while it runs
W 00 8899AABB
W 14 0000005A
R 1C 00000001
W 10 00000140
P
R 1C 00000000
W 18 C0
R 20 5A5A5A5A
R 3C 5A5A5A5A
W 18 C7
R 20 5A5A5A5A
W 18 C8
R 2C 5A5A5A5A
W 18 CF
R 3C 5A5A5A5A
W 18 24
R 20 8899AABB
W 18 00
R 2C 3A3B3C3D
W 18 80
R 28 C0C1C2C3
R 2C D0D1D2D3
# register readback and unmapped offsets
R 00 8899AABB
R 0C 30313233
R 14 0000005A
R 40 00000000
R FC 00000000
